/* hdl/qroute_bus_pkg.sv */
`default_nettype none

package qroute_bus_pkg;

	// master to slave half of the AXI4-Lite port
	typedef struct packed {
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axil_req_t;

	// slave to master half
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// register map in byte offsets
	localparam logic [7:0] reg_self        = 8'h00;
	localparam logic [7:0] reg_battery_min = 8'h04;
	localparam logic [7:0] reg_beacon_id   = 8'h08;
	localparam logic [7:0] reg_beacon_cost = 8'h0C;
	localparam logic [7:0] reg_command     = 8'h10;
	localparam logic [7:0] reg_status      = 8'h14;
	localparam logic [7:0] reg_route       = 8'h18;
	localparam logic [7:0] reg_counts      = 8'h1C;

endpackage

`default_nettype wire

/* hdl/qroute_pkg.sv */
`default_nettype none

package qroute_pkg;

	localparam int id_width    = 16;
	localparam int value_width = 16;

	// one slot of the neighbor table
	typedef struct packed {
		logic                   valid;
		logic [id_width-1:0]    id;
		logic [id_width-1:0]    cluster;
		logic [value_width-1:0] battery;
		logic [value_width-1:0] cost;
	} neighbor_t;

	// beacon as written by software
	typedef struct packed {
		logic [id_width-1:0]    id;
		logic [id_width-1:0]    cluster;
		logic [value_width-1:0] battery;
		logic [value_width-1:0] cost;
	} beacon_t;

	// identity of this node
	typedef struct packed {
		logic [id_width-1:0]    id;
		logic [id_width-1:0]    cluster;
		logic [value_width-1:0] battery_min;
	} self_cfg_t;

	// answer to a query
	typedef struct packed {
		logic                   found;
		logic                   is_destination;
		logic                   in_cluster;
		logic [id_width-1:0]    next_hop;
		logic [value_width-1:0] cost;
	} route_t;

endpackage

`default_nettype wire

/* hdl/beacon_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module beacon_writer (
	input  logic                             clock,
	input  logic                             nrst,
	input  qroute_bus_pkg::axil_req_t        bus_req,
	input  logic                             busy,
	output logic                             awready,
	output logic                             wready,
	output logic                             bvalid,
	output logic [1:0]                       bresp,
	output qroute_pkg::self_cfg_t            self_cfg,
	output qroute_pkg::beacon_t              beacon,
	output logic [qroute_pkg::id_width-1:0]  destination,
	output logic                             learn_start,
	output logic                             query_start
);

	logic        wr_accept;
	logic        cmd_write;
	logic        cmd_learn;
	logic        cmd_query;
	logic        cmd_ok;
	logic        addr_ok;
	logic [31:0] old_word;
	logic [31:0] new_word;

	// both channels at once, and only with no response outstanding
	assign wr_accept = bus_req.awvalid && bus_req.wvalid && !bvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;

	assign cmd_write = bus_req.awaddr == qroute_bus_pkg::reg_command;
	assign cmd_learn = bus_req.wdata[0] && !bus_req.wdata[1];
	assign cmd_query = bus_req.wdata[1] && !bus_req.wdata[0];
	assign cmd_ok    = !busy && (cmd_learn || cmd_query);

	// current register contents with the byte lanes merged in
	always_comb begin
		addr_ok  = 1'b1;
		old_word = '0;
		case (bus_req.awaddr)
			qroute_bus_pkg::reg_self:        old_word = {self_cfg.cluster, self_cfg.id};
			qroute_bus_pkg::reg_battery_min: old_word = {16'h0, self_cfg.battery_min};
			qroute_bus_pkg::reg_beacon_id:   old_word = {beacon.cluster, beacon.id};
			qroute_bus_pkg::reg_beacon_cost: old_word = {beacon.cost, beacon.battery};
			qroute_bus_pkg::reg_command:     old_word = '0;
			default:                         addr_ok = 1'b0;
		endcase
		for (int b = 0; b < 4; b++) begin
			new_word[b*8 +: 8] = bus_req.wstrb[b] ? bus_req.wdata[b*8 +: 8] : old_word[b*8 +: 8];
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			bvalid      <= 1'b0;
			bresp       <= qroute_bus_pkg::resp_okay;
			learn_start <= 1'b0;
			query_start <= 1'b0;
			self_cfg    <= '0;
		end else begin
			learn_start <= wr_accept && cmd_write && cmd_ok && cmd_learn;
			query_start <= wr_accept && cmd_write && cmd_ok && cmd_query;
			if (wr_accept) begin
				bvalid <= 1'b1;
				// rejected commands and unmapped offsets change nothing
				bresp <= (addr_ok && (!cmd_write || cmd_ok)) ?
					qroute_bus_pkg::resp_okay : qroute_bus_pkg::resp_slverr;
				if (bus_req.awaddr == qroute_bus_pkg::reg_self)
					{self_cfg.cluster, self_cfg.id} <= new_word;
				if (bus_req.awaddr == qroute_bus_pkg::reg_battery_min)
					self_cfg.battery_min <= new_word[15:0];
			end else if (bvalid && bus_req.bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// beacon and destination registers
	always_ff @(posedge clock) begin
		if (wr_accept) begin
			case (bus_req.awaddr)
				qroute_bus_pkg::reg_beacon_id:   {beacon.cluster, beacon.id} <= new_word;
				qroute_bus_pkg::reg_beacon_cost: {beacon.cost, beacon.battery} <= new_word;
				qroute_bus_pkg::reg_command: begin
					if (cmd_ok && cmd_query)
						destination <= bus_req.wdata[31:16];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/neighbor_table.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_table #(
	parameter int neighbors = 16
) (
	input  logic                  clock,
	input  logic                  nrst,
	input  logic                  learn_start,
	input  qroute_pkg::beacon_t   beacon,
	output qroute_pkg::neighbor_t entries [neighbors],
	output logic [7:0]            neighbor_count,
	output logic [7:0]            dropped_count,
	output logic                  learn_busy,
	output logic                  learn_done
);

	localparam int idx_width = (neighbors > 1) ? $clog2(neighbors) : 1;
	localparam int vw        = qroute_pkg::value_width;

	logic                        commit;
	logic [idx_width-1:0]        scan_idx;
	qroute_pkg::beacon_t         held;
	logic                        match_hit;
	logic [idx_width-1:0]        match_idx;
	logic                        free_hit;
	logic [idx_width-1:0]        free_idx;
	logic signed [vw:0]          cost_diff;
	logic signed [vw:0]          cost_step;
	logic [vw-1:0]               learned_cost;

	assign learn_done = commit;

	// learning step moves a quarter of the way toward the beacon cost
	assign cost_diff    = $signed({1'b0, held.cost}) - $signed({1'b0, entries[match_idx].cost});
	assign cost_step    = cost_diff >>> 2;
	assign learned_cost = entries[match_idx].cost + cost_step[vw-1:0];

	always_ff @(posedge clock) begin
		if (!nrst) begin
			learn_busy     <= 1'b0;
			commit         <= 1'b0;
			scan_idx       <= '0;
			match_hit      <= 1'b0;
			free_hit       <= 1'b0;
			neighbor_count <= '0;
			dropped_count  <= '0;
			for (int i = 0; i < neighbors; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else if (learn_start && !learn_busy) begin
			learn_busy <= 1'b1;
			held       <= beacon;
			scan_idx   <= '0;
			match_hit  <= 1'b0;
			free_hit   <= 1'b0;
		end else if (learn_busy && !commit) begin
			// one slot per cycle
			if (entries[scan_idx].valid && entries[scan_idx].id == held.id) begin
				match_hit <= 1'b1;
				match_idx <= scan_idx;
			end
			if (!entries[scan_idx].valid && !free_hit) begin
				free_hit <= 1'b1;
				free_idx <= scan_idx;
			end
			if (scan_idx == idx_width'(neighbors - 1))
				commit <= 1'b1;
			else
				scan_idx <= scan_idx + 1'b1;
		end else if (commit) begin
			commit     <= 1'b0;
			learn_busy <= 1'b0;
			if (match_hit) begin
				entries[match_idx].cluster <= held.cluster;
				entries[match_idx].battery <= held.battery;
				entries[match_idx].cost    <= learned_cost;
			end else if (free_hit) begin
				entries[free_idx] <= '{valid: 1'b1, id: held.id, cluster: held.cluster,
					battery: held.battery, cost: held.cost};
				neighbor_count <= neighbor_count + 8'd1;
			end else if (dropped_count != 8'hff) begin
				// table full so the beacon is lost
				dropped_count <= dropped_count + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/route_select.sv */
`timescale 1ns/1ps
`default_nettype none

module route_select #(
	parameter int neighbors = 16
) (
	input  logic                            clock,
	input  logic                            nrst,
	input  logic                            query_start,
	input  logic [qroute_pkg::id_width-1:0] destination,
	input  qroute_pkg::self_cfg_t           self_cfg,
	input  qroute_pkg::neighbor_t           entries [neighbors],
	output qroute_pkg::route_t              route,
	output logic                            query_busy,
	output logic                            query_done
);

	localparam int idx_width = (neighbors > 1) ? $clog2(neighbors) : 1;

	logic                                finish;
	logic [idx_width-1:0]                scan_idx;
	logic                                to_self;
	logic [qroute_pkg::id_width-1:0]     held_dest;
	logic                                direct_hit;
	logic [idx_width-1:0]                direct_idx;
	logic                                in_hit;
	logic [idx_width-1:0]                in_idx;
	logic                                out_hit;
	logic [idx_width-1:0]                out_idx;
	qroute_pkg::neighbor_t               cur;
	logic                                eligible;
	logic                                same_cluster;

	assign query_done   = finish;
	assign cur          = entries[scan_idx];
	assign eligible     = cur.valid && cur.battery >= self_cfg.battery_min;
	assign same_cluster = cur.cluster == self_cfg.cluster;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			query_busy <= 1'b0;
			finish     <= 1'b0;
			scan_idx   <= '0;
			route      <= '0;
		end else if (query_start && !query_busy) begin
			query_busy <= 1'b1;
			scan_idx   <= '0;
			held_dest  <= destination;
			to_self    <= destination == self_cfg.id;
			direct_hit <= 1'b0;
			in_hit     <= 1'b0;
			out_hit    <= 1'b0;
		end else if (query_busy && !finish) begin
			if (cur.valid && cur.id == held_dest) begin
				direct_hit <= 1'b1;
				direct_idx <= scan_idx;
			end
			// strictly greater so ties stay on the lower slot
			if (eligible && same_cluster && (!in_hit || cur.cost > entries[in_idx].cost)) begin
				in_hit <= 1'b1;
				in_idx <= scan_idx;
			end
			if (eligible && !same_cluster && (!out_hit || cur.cost > entries[out_idx].cost)) begin
				out_hit <= 1'b1;
				out_idx <= scan_idx;
			end
			if (scan_idx == idx_width'(neighbors - 1))
				finish <= 1'b1;
			else
				scan_idx <= scan_idx + 1'b1;
		end else if (finish) begin
			finish     <= 1'b0;
			query_busy <= 1'b0;
			if (to_self)
				route <= '{found: 1'b1, is_destination: 1'b1, in_cluster: 1'b1,
					next_hop: self_cfg.id, cost: '0};
			else if (direct_hit)
				route <= '{found: 1'b1, is_destination: 1'b0,
					in_cluster: entries[direct_idx].cluster == self_cfg.cluster,
					next_hop: entries[direct_idx].id, cost: entries[direct_idx].cost};
			else if (in_hit)
				route <= '{found: 1'b1, is_destination: 1'b0, in_cluster: 1'b1,
					next_hop: entries[in_idx].id, cost: entries[in_idx].cost};
			else if (out_hit)
				route <= '{found: 1'b1, is_destination: 1'b0, in_cluster: 1'b0,
					next_hop: entries[out_idx].id, cost: entries[out_idx].cost};
			else
				route <= '0;
		end
	end

endmodule

`default_nettype wire

/* hdl/result_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module result_reader #(
	parameter int neighbors = 16
) (
	input  logic                      clock,
	input  logic                      nrst,
	input  qroute_bus_pkg::axil_req_t bus_req,
	input  logic                      busy,
	input  qroute_pkg::route_t        route,
	input  logic [7:0]                neighbor_count,
	input  logic [7:0]                dropped_count,
	output logic                      arready,
	output logic                      rvalid,
	output logic [31:0]               rdata,
	output logic [1:0]                rresp
);

	logic [31:0] read_word;
	logic [1:0]  read_resp;

	assign arready = bus_req.arvalid && !rvalid;

	always_comb begin
		read_word = '0;
		read_resp = qroute_bus_pkg::resp_okay;
		case (bus_req.araddr)
			qroute_bus_pkg::reg_status:
				read_word = {28'h0, route.in_cluster, route.is_destination, route.found, busy};
			qroute_bus_pkg::reg_route:
				read_word = {route.cost, route.next_hop};
			// table depth rides in the third byte
			qroute_bus_pkg::reg_counts:
				read_word = {8'h0, 8'(neighbors), dropped_count, neighbor_count};
			default:
				read_resp = qroute_bus_pkg::resp_slverr;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!nrst)
			rvalid <= 1'b0;
		else if (arready)
			rvalid <= 1'b1;
		else if (rvalid && bus_req.rready)
			rvalid <= 1'b0;
	end

	// data captured at acceptance and held while rvalid waits
	always_ff @(posedge clock) begin
		if (arready) begin
			rdata <= read_word;
			rresp <= read_resp;
		end
	end

endmodule

`default_nettype wire

/* hdl/qroute_top.sv */
`timescale 1ns/1ps
`default_nettype none

module qroute_top #(
	parameter int neighbors = 16
) (
	input  logic                      clock,
	input  logic                      nrst,
	input  qroute_bus_pkg::axil_req_t bus_req,
	output qroute_bus_pkg::axil_rsp_t bus_rsp
);

	qroute_pkg::self_cfg_t           self_cfg;
	qroute_pkg::beacon_t             beacon;
	logic [qroute_pkg::id_width-1:0] destination;
	logic                            learn_start;
	logic                            query_start;
	qroute_pkg::neighbor_t           entries [neighbors];
	logic [7:0]                      neighbor_count;
	logic [7:0]                      dropped_count;
	logic                            learn_busy;
	logic                            query_busy;
	qroute_pkg::route_t              route;
	logic                            busy;

	// start pulses count as busy so a status poll never sees a gap
	assign busy = learn_busy || query_busy || learn_start || query_start;

	// write half of the response
	beacon_writer u_beacon_writer (
		.clock(clock), .nrst(nrst), .bus_req(bus_req), .busy(busy),
		.awready(bus_rsp.awready), .wready(bus_rsp.wready),
		.bvalid(bus_rsp.bvalid), .bresp(bus_rsp.bresp),
		.self_cfg(self_cfg), .beacon(beacon), .destination(destination),
		.learn_start(learn_start), .query_start(query_start)
	);

	neighbor_table #(.neighbors(neighbors)) u_neighbor_table (
		.clock(clock), .nrst(nrst), .learn_start(learn_start), .beacon(beacon),
		.entries(entries), .neighbor_count(neighbor_count),
		.dropped_count(dropped_count), .learn_busy(learn_busy), .learn_done()
	);

	route_select #(.neighbors(neighbors)) u_route_select (
		.clock(clock), .nrst(nrst), .query_start(query_start),
		.destination(destination), .self_cfg(self_cfg), .entries(entries),
		.route(route), .query_busy(query_busy), .query_done()
	);

	// read half of the response
	result_reader #(.neighbors(neighbors)) u_result_reader (
		.clock(clock), .nrst(nrst), .bus_req(bus_req), .busy(busy), .route(route),
		.neighbor_count(neighbor_count), .dropped_count(dropped_count),
		.arready(bus_rsp.arready), .rvalid(bus_rsp.rvalid),
		.rdata(bus_rsp.rdata), .rresp(bus_rsp.rresp)
	);

endmodule

`default_nettype wire

/* verification/qroute_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module qroute_sva (
	input logic                      clock,
	input logic                      nrst,
	input qroute_bus_pkg::axil_req_t bus_req,
	input qroute_bus_pkg::axil_rsp_t bus_rsp,
	input logic                      busy
);

	int hold_fails = 0;
	int stable_fails = 0;
	int response_fails = 0;
	int reset_fails = 0;
	int failures;

	assign failures = hold_fails + stable_fails + response_fails + reset_fails;

	bvalid_hold: assert property (@(posedge clock) disable iff (!nrst)
		bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid)
	else begin
		hold_fails++;
		$error("bvalid dropped before bready");
	end

	// read data frozen while the master stalls
	rdata_stable: assert property (@(posedge clock) disable iff (!nrst)
		bus_rsp.rvalid && !bus_req.rready |=> bus_rsp.rvalid && $stable(bus_rsp.rdata))
	else begin
		stable_fails++;
		$error("rdata changed or rvalid dropped while waiting for rready");
	end

	// an accepted write is answered on the next clock
	write_response: assert property (@(posedge clock) disable iff (!nrst)
		bus_rsp.awready |=> bus_rsp.bvalid)
	else begin
		response_fails++;
		$error("no write response on the clock after awready");
	end

	busy_after_reset: assert property (@(posedge clock) !nrst |=> !busy)
	else begin
		reset_fails++;
		$error("busy high right after reset");
	end

endmodule

`default_nettype wire

/* verification/qroute_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module qroute_checker (
	input  logic                      clock,
	input  logic                      nrst,
	input  qroute_bus_pkg::axil_req_t bus_req,
	input  qroute_bus_pkg::axil_rsp_t bus_rsp,
	input  logic                      exp_push,
	input  logic                      exp_write,
	input  logic                      exp_check,
	input  logic [31:0]               exp_rdata,
	input  logic [1:0]                exp_resp,
	output int                        data_errors,
	output int                        resp_errors,
	output int                        protocol_errors
);

	typedef struct packed {
		logic        check;
		logic [7:0]  offset;
		logic [31:0] rdata;
		logic [1:0]  resp;
	} expect_t;

	expect_t read_q [$];
	expect_t write_q [$];
	expect_t read_cur;
	expect_t write_cur;

	always @(posedge clock) begin
		if (!nrst) begin
			data_errors     = 0;
			resp_errors     = 0;
			protocol_errors = 0;
			read_q.delete();
			write_q.delete();
		end else begin
			if (exp_push) begin
				if (exp_write)
					write_q.push_back('{exp_check, 8'h0, exp_rdata, exp_resp});
				else
					read_q.push_back('{exp_check, 8'h0, exp_rdata, exp_resp});
			end
			// address and data channels are accepted in the same cycle
			if (bus_rsp.awready != bus_rsp.wready) begin
				$display("awready and wready did not pulse together at offset %h",
					bus_req.awaddr);
				protocol_errors++;
			end
			// pair each accepted address with the oldest expectation
			if (bus_req.awvalid && bus_rsp.awready) begin
				if (write_q.size() == 0) begin
					$display("write accepted with no expected response queued");
					protocol_errors++;
					write_cur = '0;
				end else begin
					write_cur = write_q.pop_front();
				end
				write_cur.offset = bus_req.awaddr;
			end
			if (bus_req.arvalid && bus_rsp.arready) begin
				if (read_q.size() == 0) begin
					$display("read accepted with no expected value queued");
					protocol_errors++;
					read_cur = '0;
				end else begin
					read_cur = read_q.pop_front();
				end
				read_cur.offset = bus_req.araddr;
			end
			if (bus_rsp.bvalid && bus_req.bready && write_cur.check) begin
				if (bus_rsp.bresp != write_cur.resp) begin
					$display("mismatch bresp at offset %h: got %h, expected %h",
						write_cur.offset, bus_rsp.bresp, write_cur.resp);
					resp_errors++;
				end
			end
			if (bus_rsp.rvalid && bus_req.rready && read_cur.check) begin
				if (bus_rsp.rdata != read_cur.rdata) begin
					$display("mismatch rdata at offset %h: got %h, expected %h",
						read_cur.offset, bus_rsp.rdata, read_cur.rdata);
					data_errors++;
				end
				if (bus_rsp.rresp != read_cur.resp) begin
					$display("mismatch rresp at offset %h: got %h, expected %h",
						read_cur.offset, bus_rsp.rresp, read_cur.resp);
					resp_errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/qroute_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module qroute_tb;

	localparam int period = 100;
	localparam int depth  = 4;

	logic                      clock;
	logic                      nrst;
	qroute_bus_pkg::axil_req_t bus_req;
	qroute_bus_pkg::axil_rsp_t bus_rsp;

	// expected values handed to the checker
	logic        exp_push;
	logic        exp_write;
	logic        exp_check;
	logic [31:0] exp_rdata;
	logic [1:0]  exp_resp;

	int data_errors;
	int resp_errors;
	int protocol_errors;
	int setup_errors;
	int seed = 32'h1707_3c81;
	logic loaded;

	logic [7:0]  op_list [$];
	logic [7:0]  off_list [$];
	logic [31:0] data_list [$];
	logic [31:0] expd_list [$];
	logic [1:0]  resp_list [$];

	qroute_top #(.neighbors(depth)) u_qroute_top (
		.clock(clock), .nrst(nrst), .bus_req(bus_req), .bus_rsp(bus_rsp)
	);

	qroute_checker u_qroute_checker (
		.clock(clock), .nrst(nrst), .bus_req(bus_req), .bus_rsp(bus_rsp),
		.exp_push(exp_push), .exp_write(exp_write), .exp_check(exp_check),
		.exp_rdata(exp_rdata), .exp_resp(exp_resp),
		.data_errors(data_errors), .resp_errors(resp_errors),
		.protocol_errors(protocol_errors)
	);

	bind qroute_top qroute_sva u_qroute_sva (
		.clock(clock), .nrst(nrst), .bus_req(bus_req), .bus_rsp(bus_rsp), .busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	task automatic queue_expect(input logic write, input logic check,
		input logic [31:0] rdata, input logic [1:0] resp);
		exp_write = write;
		exp_check = check;
		exp_rdata = rdata;
		exp_resp  = resp;
		exp_push  = 1'b1;
	endtask

	task automatic write_reg(input logic [7:0] offset, input logic [31:0] data,
		input logic [1:0] resp);
		int delay;
		bus_req.awvalid = 1'b1;
		bus_req.awaddr  = offset;
		bus_req.wvalid  = 1'b1;
		bus_req.wdata   = data;
		bus_req.wstrb   = 4'hf;
		queue_expect(1'b1, 1'b1, 32'h0, resp);
		do begin
			@(negedge clock);
			exp_push = 1'b0;
		end while (!bus_rsp.bvalid);
		bus_req.awvalid = 1'b0;
		bus_req.wvalid  = 1'b0;
		delay = $unsigned($random(seed)) % 3;
		repeat (delay) @(negedge clock);
		bus_req.bready = 1'b1;
		do @(negedge clock); while (bus_rsp.bvalid);
		bus_req.bready = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] offset, input logic check,
		input logic [31:0] rdata, input logic [1:0] resp, output logic [31:0] word);
		int delay;
		bus_req.arvalid = 1'b1;
		bus_req.araddr  = offset;
		queue_expect(1'b0, check, rdata, resp);
		do begin
			@(negedge clock);
			exp_push = 1'b0;
		end while (!bus_rsp.rvalid);
		bus_req.arvalid = 1'b0;
		word = bus_rsp.rdata;
		delay = $unsigned($random(seed)) % 3;
		repeat (delay) @(negedge clock);
		bus_req.rready = 1'b1;
		do @(negedge clock); while (bus_rsp.rvalid);
		bus_req.rready = 1'b0;
	endtask

	// status bit 0 is the busy flag
	task automatic poll_idle();
		logic [31:0] word;
		word = 32'h1;
		while (word[0]) begin
			read_reg(qroute_bus_pkg::reg_status, 1'b0, 32'h0, qroute_bus_pkg::resp_okay, word);
		end
	endtask

	task automatic load_cases();
		int fd;
		int ch;
		int n;
		logic [7:0]  op;
		logic [7:0]  offset;
		logic [31:0] data;
		logic [31:0] expect_data;
		logic [1:0]  expect_resp;
		fd = $fopen("verification/qroute_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/qroute_cases.txt");
			setup_errors++;
			return;
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				n = $fscanf(fd, " %h %h %h %h", offset, data, expect_data, expect_resp);
				if (n != 4) begin
					$display("malformed line in the cases file after %0d cases", op_list.size());
					setup_errors++;
					break;
				end
				op_list.push_back(op);
				off_list.push_back(offset);
				data_list.push_back(data);
				expd_list.push_back(expect_data);
				resp_list.push_back(expect_resp);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_case(input int i);
		logic [31:0] word;
		case (op_list[i])
			"w": write_reg(off_list[i], data_list[i], resp_list[i]);
			"r": read_reg(off_list[i], 1'b1, expd_list[i], resp_list[i], word);
			"p": poll_idle();
			default: begin
				$display("unknown operation in case %0d", i);
				setup_errors++;
			end
		endcase
	endtask

	// watchdog sized from the number of cases
	initial begin
		wait (loaded);
		#((op_list.size() * 40 + 10) * period);
		$display("run timed out after %0d cases worth of clock periods", op_list.size());
		$display("Verification failed");
		$finish;
	end

	initial begin
		int total;
		bus_req      = '0;
		nrst         = 1'b0;
		exp_push     = 1'b0;
		exp_write    = 1'b0;
		exp_check    = 1'b0;
		exp_rdata    = '0;
		exp_resp     = '0;
		setup_errors = 0;
		loaded       = 1'b0;
		load_cases();
		loaded = 1'b1;
		repeat (3) @(negedge clock);
		nrst = 1'b1;
		@(negedge clock);
		for (int i = 0; i < op_list.size(); i++) begin
			run_case(i);
		end
		repeat (2) @(negedge clock);
		total = data_errors + resp_errors + protocol_errors + setup_errors
			+ u_qroute_top.u_qroute_sva.failures;
		$display("errors: rdata %0d, resp %0d, protocol %0d, assertion %0d, setup %0d",
			data_errors, resp_errors, protocol_errors,
			u_qroute_top.u_qroute_sva.failures, setup_errors);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/qroute_cases.txt */
# op offset data expected_rdata expected_resp, all hex
# w write, r read and compare, p poll status until not busy
w 00 000a0001 00000000 0
w 04 00000020 00000000 0
w 08 000a0011 00000000 0
w 0c 00400030 00000000 0
w 10 00000001 00000000 0
p 14 00000000 00000000 0
w 08 000a0012 00000000 0
w 0c 00900010 00000000 0
w 10 00000001 00000000 0
p 14 00000000 00000000 0
w 08 000b0021 00000000 0
w 0c 00800050 00000000 0
w 10 00000001 00000000 0
p 14 00000000 00000000 0
w 08 000a0013 00000000 0
w 0c 00600040 00000000 0
w 10 00000001 00000000 0
p 14 00000000 00000000 0
r 1c 00000000 00040004 0
w 08 000b0030 00000000 0
w 10 00000001 00000000 0
p 14 00000000 00000000 0
r 1c 00000000 00040104 0
# direct hit on a known neighbor, low battery does not matter
w 10 00120002 00000000 0
p 14 00000000 00000000 0
r 14 00000000 0000000a 0
r 18 00000000 00900012 0
# unknown destination picks best own cluster entry
w 10 00550002 00000000 0
p 14 00000000 00000000 0
r 18 00000000 00600013 0
# relearn 0x13 toward cost 0, 0x60 becomes 0x48
w 08 000a0013 00000000 0
w 0c 00000040 00000000 0
w 10 00000001 00000000 0
p 14 00000000 00000000 0
w 10 00550002 00000000 0
p 14 00000000 00000000 0
r 18 00000000 00480013 0
# again, 0x48 becomes 0x36 and 0x11 wins
w 10 00000001 00000000 0
p 14 00000000 00000000 0
w 10 00550002 00000000 0
p 14 00000000 00000000 0
r 18 00000000 00400011 0
r 1c 00000000 00040104 0
# own id
w 10 00010002 00000000 0
p 14 00000000 00000000 0
r 14 00000000 0000000e 0
r 18 00000000 00000001 0
# own cluster below threshold, other cluster used
w 04 00000045 00000000 0
w 10 00550002 00000000 0
p 14 00000000 00000000 0
r 14 00000000 00000002 0
r 18 00000000 00800021 0
# nothing eligible
w 04 00000060 00000000 0
w 10 00550002 00000000 0
p 14 00000000 00000000 0
r 14 00000000 00000000 0
r 18 00000000 00000000 0
# rejected commands leave the counts alone
w 08 000b0030 00000000 0
w 10 00000003 00000000 2
w 10 00000000 00000000 2
w 10 00120002 00000000 0
w 10 00000001 00000000 2
p 14 00000000 00000000 0
r 18 00000000 00900012 0
r 1c 00000000 00040104 0
# unmapped and write only offsets
w 24 12345678 00000000 2
r 04 00000000 00000000 2
r 20 00000000 00000000 2

/* src.f */
hdl/qroute_bus_pkg.sv
hdl/qroute_pkg.sv
hdl/beacon_writer.sv
hdl/neighbor_table.sv
hdl/route_select.sv
hdl/result_reader.sv
hdl/qroute_top.sv
verification/qroute_sva.sv
verification/qroute_checker.sv
verification/qroute_tb.sv

/* run.sh */
#!/bin/sh
# build and run the qroute testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module qroute_tb -f src.f -o qroute_sim

./obj_dir/qroute_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
exit 1
